// File: compile.f
rtl/lc3b_types.sv
rtl/ex_mem_resolve_if.sv
rtl/branch_waterfall_queue.sv
rtl/branch_predictor.sv
rtl/fetch_stage.sv
rtl/branch_controller.sv
rtl/branch_unit_top.sv
testbench/branch_unit_checker.sv
testbench/tb_branch_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only if the log shows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_branch_unit -o tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    && grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/tb_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_unit;
    import lc3b_types::*;

    localparam lc3b_word reset_vector = 16'h3000;
    localparam int       queue_depth  = 4;
    localparam int       index_bits   = PHT_INDEX_BITS;

    logic clk;
    logic reset;
    logic stall;
    lc3b_word if_ir;
    logic if_valid;
    logic ex_mem_valid;
    lc3b_opcode ex_mem_opcode;
    lc3b_word ex_mem_alu;
    lc3b_word ex_mem_pcn;
    lc3b_pc_mux_sel ex_mem_pc_mux_sel;
    logic mem_br_en;
    logic mem_wb_valid;
    lc3b_opcode mem_wb_opcode;
    lc3b_word mem_wb_mdr;
    lc3b_word if_pc;
    lc3b_word pc_out;
    lc3b_word pc_plus2_out;
    logic flush_active;
    logic flush_if_id;
    logic flush_id_ex;
    logic flush_ex_mem;
    logic flush_mem_wb;
    logic debug_prediction_correct;
    logic debug_prediction_incorrect;
    int error_count;

    logic [31:0] lfsr_state;
    logic br_stage0;   // issued last cycle
    logic br_stage1;   // resolves at ex/mem this cycle
    logic flush_seen;
    logic timed_out;
    int   errors_before;

    always #4 clk = ~clk;

    always @(negedge clk) flush_seen = flush_if_id;

    branch_unit_top #(
        .reset_vector (reset_vector),
        .queue_depth  (queue_depth),
        .index_bits   (index_bits)
    ) i_dut (.*);

    branch_unit_checker #(
        .reset_vector (reset_vector),
        .queue_depth  (queue_depth),
        .index_bits   (index_bits)
    ) i_checker (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic idle_inputs();
        stall         = 1'b0;
        if_valid      = 1'b0;
        if_ir         = 16'h0000;
        ex_mem_valid  = 1'b0;
        ex_mem_opcode = op_add;
        ex_mem_alu    = 16'h0000;
        ex_mem_pcn    = 16'h0000;
        ex_mem_pc_mux_sel = lc3b_pc_mux_sel_pc_plus2;
        mem_br_en     = 1'b0;
        mem_wb_valid  = 1'b0;
        mem_wb_opcode = op_add;
        mem_wb_mdr    = 16'h0000;
    endtask

    // mode 0 issues no branch, 1 random branches, 2 short loops biased taken
    task automatic stream_cycle(input int mode);
        logic [15:0] r;
        @(posedge clk);
        #1;
        idle_inputs();
        if (flush_seen) begin
            br_stage0 = 1'b0;
            br_stage1 = 1'b0;
        end
        random_bits(16, r);
        ex_mem_valid  = br_stage1;
        ex_mem_opcode = op_br;
        mem_br_en     = (mode == 2) ? (r[0] | r[1]) : r[0];
        br_stage1     = br_stage0;
        br_stage0     = (mode != 0) && r[2];
        if_valid      = 1'b1;
        if (br_stage0) begin
            if_ir = (mode == 2) ? {7'b0000_111, 6'b0, r[4:3], 1'b0} : {7'b0000_111, r[11:3]};
        end else begin
            if_ir = {4'b0001, r[14:3]};
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((br_stage0 || br_stage1) && cycles < 10) begin
            stream_cycle(0);
            cycles++;
        end
        if (br_stage0 || br_stage1) begin
            timed_out = 1'b1;
            $display("timeout: branches still in flight after drain");
        end
        stream_cycle(0);
    endtask

    task automatic stall_cycles(input int n);
        if (flush_seen) begin
            br_stage0 = 1'b0;
            br_stage1 = 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            idle_inputs();
            stall = 1'b1;
        end
    endtask

    // --------------------
    // jmp, jsr and traps
    task automatic control_flow_cycle();
        logic [15:0] r;
        logic [15:0] a;
        logic [15:0] b;
        drain();
        random_bits(5, r);
        random_bits(16, a);
        random_bits(16, b);
        @(posedge clk);
        #1;
        idle_inputs();
        if_valid      = 1'b1;
        if_ir         = r[3] ? {7'b0000_111, a[8:0]} : {4'b0001, b[11:0]};
        ex_mem_valid  = 1'b1;
        ex_mem_opcode = r[0] ? op_jsr : op_jmp;
        ex_mem_alu    = a;
        ex_mem_pcn    = b;
        ex_mem_pc_mux_sel = (r[0] && r[1]) ? lc3b_pc_mux_sel_pcn : lc3b_pc_mux_sel_alu;
        if (r[2]) begin
            ex_mem_opcode = op_trap;
        end
        mem_wb_valid  = r[4];   // overrides the ex/mem redirect
        mem_wb_opcode = op_trap;
        mem_wb_mdr    = a ^ b;
        br_stage0     = 1'b0;
    endtask

    task automatic report(input string name);
        $display("test %s: %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        lfsr_state    = 32'h5217_f789;
        br_stage0     = 1'b0;
        br_stage1     = 1'b0;
        flush_seen    = 1'b0;
        timed_out     = 1'b0;
        errors_before = 0;
        idle_inputs();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 8; i++) stream_cycle(0);
        stall_cycles(3);
        for (int i = 0; i < 4; i++) stream_cycle(0);
        report("reset and sequential fetch");

        for (int i = 0; i < 60; i++) stream_cycle(1);
        drain();
        report("branch prediction at fetch");

        for (int i = 0; i < 80; i++) stream_cycle(1);
        drain();
        report("branch resolution");

        for (int i = 0; i < 120; i++) stream_cycle(2);
        drain();
        report("predictor training");

        for (int i = 0; i < 24; i++) control_flow_cycle();
        drain();
        report("jumps and traps");

        $display("checks done, %0d errors, timeout %0d", error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_branch_unit

`default_nettype wire

// File: testbench/branch_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit_checker #(
    parameter lc3b_types::lc3b_word reset_vector = 16'h0000,
    parameter int                   queue_depth  = 4,
    parameter int                   index_bits   = 6
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  lc3b_types::lc3b_word       if_ir,
    input  logic                       if_valid,
    input  logic                       ex_mem_valid,
    input  lc3b_types::lc3b_opcode     ex_mem_opcode,
    input  lc3b_types::lc3b_word       ex_mem_alu,
    input  lc3b_types::lc3b_word       ex_mem_pcn,
    input  lc3b_types::lc3b_pc_mux_sel ex_mem_pc_mux_sel,
    input  logic                       mem_br_en,
    input  logic                       mem_wb_valid,
    input  lc3b_types::lc3b_opcode     mem_wb_opcode,
    input  lc3b_types::lc3b_word       mem_wb_mdr,
    input  lc3b_types::lc3b_word       if_pc,
    input  lc3b_types::lc3b_word       pc_out,
    input  lc3b_types::lc3b_word       pc_plus2_out,
    input  logic                       flush_active,
    input  logic                       flush_if_id,
    input  logic                       flush_id_ex,
    input  logic                       flush_ex_mem,
    input  logic                       flush_mem_wb,
    input  logic                       debug_prediction_correct,
    input  logic                       debug_prediction_incorrect,
    output int                         error_count
);
    import lc3b_types::*;

    logic [1:0]            pht [2**index_bits];
    lc3b_word              model_pc;
    lc3b_word              q_alt [$];
    logic                  q_pred [$];
    logic [index_bits-1:0] q_idx [$];
    logic                  pend_train;
    logic                  pend_taken;
    logic [index_bits-1:0] pend_idx;
    logic                  train_valid;   // predictor update input this cycle
    logic                  train_taken;
    logic [index_bits-1:0] train_idx;

    initial error_count = 0;

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // --------------------
    // sampled mid-cycle so state mirrors the next rising edge
    always @(negedge clk) begin
        lc3b_word              exp_pc;
        lc3b_word              br_addr;
        lc3b_word              head_alt;
        logic                  head_pred;
        logic [index_bits-1:0] head_idx;
        logic [index_bits-1:0] if_idx;
        logic                  if_br;
        logic                  ex_br;
        logic                  ex_jump;
        logic                  ex_trap;
        logic                  wb_trap;
        logic                  pred;
        logic                  miss;
        logic                  f3;
        logic                  push_ok;
        if (reset) begin
            for (int i = 0; i < 2**index_bits; i++) begin
                pht[i] = 2'b01;
            end
            model_pc = reset_vector;
            q_alt.delete();
            q_pred.delete();
            q_idx.delete();
            pend_train  = 1'b0;
            train_valid = 1'b0;
        end else begin
            if (train_valid) begin   // trained at the edge just past
                if (train_taken) begin
                    if (pht[train_idx] != 2'b11) begin
                        pht[train_idx] = pht[train_idx] + 2'd1;
                    end
                end else begin
                    if (pht[train_idx] != 2'b00) begin
                        pht[train_idx] = pht[train_idx] - 2'd1;
                    end
                end
            end
            train_valid = pend_train;   // resolved last cycle, written at the next edge
            train_taken = pend_taken;
            train_idx   = pend_idx;

            if_idx    = if_pc[index_bits:1];
            pred      = pht[if_idx][1];
            head_alt  = (q_alt.size() != 0) ? q_alt[0] : 16'h0000;
            head_pred = (q_pred.size() != 0) ? q_pred[0] : 1'b0;
            head_idx  = (q_idx.size() != 0) ? q_idx[0] : '0;
            br_addr   = if_pc + {7'b0, if_ir[8:0]};
            if_br     = if_valid && if_ir[15:12] == 4'b0000;
            ex_br     = ex_mem_valid && ex_mem_opcode == op_br;
            ex_jump   = ex_mem_valid && (ex_mem_opcode == op_jmp || ex_mem_opcode == op_jsr);
            ex_trap   = ex_mem_valid && ex_mem_opcode == op_trap;
            wb_trap   = mem_wb_valid && mem_wb_opcode == op_trap;
            miss      = ex_br && head_pred != mem_br_en;
            f3        = wb_trap || ex_jump || ex_trap || miss;

            // next pc, highest priority first
            if (wb_trap) exp_pc = mem_wb_mdr;
            else if (ex_jump) begin
                exp_pc = (ex_mem_pc_mux_sel == lc3b_pc_mux_sel_alu) ? ex_mem_alu : ex_mem_pcn;
            end else if (ex_br) exp_pc = miss ? head_alt : if_pc + 16'd2;
            else if (if_br && pred) exp_pc = br_addr;
            else exp_pc = if_pc + 16'd2;

            compare("if_pc", model_pc, if_pc);
            compare("pc_out", exp_pc, pc_out);
            compare("pc_plus2_out", if_pc + 16'd2, pc_plus2_out);
            compare("flush_if_id", {15'b0, f3}, {15'b0, flush_if_id});
            compare("flush_id_ex", {15'b0, f3}, {15'b0, flush_id_ex});
            compare("flush_ex_mem", {15'b0, f3}, {15'b0, flush_ex_mem});
            compare("flush_mem_wb", {15'b0, wb_trap}, {15'b0, flush_mem_wb});
            compare("flush_active", {15'b0, f3}, {15'b0, flush_active});
            compare("debug_prediction_correct", {15'b0, ex_br && !miss},
                    {15'b0, debug_prediction_correct});
            compare("debug_prediction_incorrect", {15'b0, miss},
                    {15'b0, debug_prediction_incorrect});

            pend_train = ex_br && q_alt.size() != 0;
            pend_taken = mem_br_en;
            pend_idx   = head_idx;
            if (miss || ex_jump || ex_trap) begin   // younger branches squashed
                q_alt.delete();
                q_pred.delete();
                q_idx.delete();
            end else begin
                push_ok = if_br && q_alt.size() < queue_depth;
                if (ex_br && q_alt.size() != 0) begin
                    void'(q_alt.pop_front());
                    void'(q_pred.pop_front());
                    void'(q_idx.pop_front());
                end
                if (push_ok) begin
                    q_alt.push_back(pred ? if_pc + 16'd2 : br_addr);
                    q_pred.push_back(pred);
                    q_idx.push_back(if_idx);
                end
            end
            if (!stall) model_pc = exp_pc;
        end
    end

endmodule : branch_unit_checker

`default_nettype wire

// File: rtl/branch_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit_top #(
    parameter lc3b_types::lc3b_word reset_vector = 16'h0000,
    parameter int                   queue_depth  = 4,
    parameter int                   index_bits   = lc3b_types::PHT_INDEX_BITS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  lc3b_types::lc3b_word       if_ir,
    input  logic                       if_valid,
    input  logic                       ex_mem_valid,
    input  lc3b_types::lc3b_opcode     ex_mem_opcode,
    input  lc3b_types::lc3b_word       ex_mem_alu,
    input  lc3b_types::lc3b_word       ex_mem_pcn,
    input  lc3b_types::lc3b_pc_mux_sel ex_mem_pc_mux_sel,
    input  logic                       mem_br_en,
    input  logic                       mem_wb_valid,
    input  lc3b_types::lc3b_opcode     mem_wb_opcode,
    input  lc3b_types::lc3b_word       mem_wb_mdr,
    output lc3b_types::lc3b_word       if_pc,
    output lc3b_types::lc3b_word       pc_out,
    output lc3b_types::lc3b_word       pc_plus2_out,
    output logic                       flush_active,
    output logic                       flush_if_id,
    output logic                       flush_id_ex,
    output logic                       flush_ex_mem,
    output logic                       flush_mem_wb,
    output logic                       debug_prediction_correct,
    output logic                       debug_prediction_incorrect
);
    import lc3b_types::*;

    lc3b_pipeline_control_word control_request;
    logic                      prediction;
    logic                      train;
    logic                      train_taken;
    logic [index_bits-1:0]     train_index;

    ex_mem_resolve_if ex_mem_bus ();

    // --------------------
    // ex/mem barrier fields
    assign ex_mem_bus.valid      = ex_mem_valid;
    assign ex_mem_bus.opcode     = ex_mem_opcode;
    assign ex_mem_bus.alu        = ex_mem_alu;
    assign ex_mem_bus.pcn        = ex_mem_pcn;
    assign ex_mem_bus.pc_mux_sel = ex_mem_pc_mux_sel;
    assign ex_mem_bus.br_en      = mem_br_en;

    assign flush_active = control_request.active;
    assign flush_if_id  = control_request.barrier_if_id_reset;
    assign flush_id_ex  = control_request.barrier_id_ex_reset;
    assign flush_ex_mem = control_request.barrier_ex_mem_reset;
    assign flush_mem_wb = control_request.barrier_mem_wb_reset;

    fetch_stage #(
        .reset_vector (reset_vector),
        .index_bits   (index_bits)
    ) i_fetch (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .next_pc     (pc_out),
        .pc          (if_pc),
        .prediction  (prediction),
        .train       (train),
        .train_taken (train_taken),
        .train_index (train_index)
    );

    branch_controller #(
        .queue_depth (queue_depth),
        .index_bits  (index_bits)
    ) i_controller (
        .clk                        (clk),
        .reset                      (reset),
        .if_ir                      (if_ir),
        .if_pc                      (if_pc),
        .if_valid                   (if_valid),
        .branch_prediction          (prediction),
        .ex_mem                     (ex_mem_bus.controller),
        .mem_wb_mdr                 (mem_wb_mdr),
        .mem_wb_opcode              (mem_wb_opcode),
        .mem_wb_valid               (mem_wb_valid),
        .pc_out                     (pc_out),
        .pc_plus2_out               (pc_plus2_out),
        .control_request            (control_request),
        .train                      (train),
        .train_taken                (train_taken),
        .train_index                (train_index),
        .debug_prediction_correct   (debug_prediction_correct),
        .debug_prediction_incorrect (debug_prediction_incorrect)
    );

endmodule : branch_unit_top

`default_nettype wire

// File: rtl/branch_controller.sv
`timescale 1ns/1ps
`default_nettype none

module branch_controller #(
    parameter int queue_depth = 4,
    parameter int index_bits  = 6
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  lc3b_types::lc3b_word                  if_ir,
    input  lc3b_types::lc3b_word                  if_pc,
    input  logic                                  if_valid,
    input  logic                                  branch_prediction,
    ex_mem_resolve_if.controller                  ex_mem,
    input  lc3b_types::lc3b_word                  mem_wb_mdr,
    input  lc3b_types::lc3b_opcode                mem_wb_opcode,
    input  logic                                  mem_wb_valid,
    output lc3b_types::lc3b_word                  pc_out,
    output lc3b_types::lc3b_word                  pc_plus2_out,
    output lc3b_types::lc3b_pipeline_control_word control_request,
    output logic                                  train,
    output logic                                  train_taken,
    output logic [index_bits-1:0]                 train_index,
    output logic                                  debug_prediction_correct,
    output logic                                  debug_prediction_incorrect
);
    import lc3b_types::*;

    lc3b_opcode       if_opcode;
    lc3b_word         branch_address;
    lc3b_pc_mux_sel   pc_mux_sel;
    lc3b_branch_entry push_entry;
    lc3b_branch_entry head_entry;
    logic             if_br;
    logic             ex_br;
    logic             ex_jump;
    logic             ex_trap;
    logic             wb_trap;
    logic             mispredict;
    logic             queue_flush;
    logic [$clog2(queue_depth+1)-1:0] queue_count;

    assign if_opcode      = lc3b_opcode'(if_ir[15:12]);
    assign branch_address = if_pc + {7'b0, if_ir[8:0]};
    assign pc_plus2_out   = if_pc + 16'd2;

    assign if_br   = if_valid && (if_opcode == op_br);
    assign ex_br   = ex_mem.valid && (ex_mem.opcode == op_br);
    assign ex_jump = ex_mem.valid && (ex_mem.opcode == op_jmp || ex_mem.opcode == op_jsr);
    assign ex_trap = ex_mem.valid && (ex_mem.opcode == op_trap);
    assign wb_trap = mem_wb_valid && (mem_wb_opcode == op_trap);

    assign mispredict  = ex_br && (head_entry.prediction != ex_mem.br_en);
    assign queue_flush = mispredict || ex_jump || ex_trap; // younger branches are squashed

    // --------------------
    // in-flight predictions
    always_comb begin
        push_entry.prediction        = branch_prediction;
        push_entry.alternate_address = branch_prediction ? pc_plus2_out : branch_address;
        push_entry.pht_index         = if_pc[index_bits:1];
    end

    branch_waterfall_queue #(
        .payload_t (lc3b_branch_entry),
        .depth     (queue_depth)
    ) i_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (if_br),
        .pop       (ex_br),
        .flush     (queue_flush),
        .push_data (push_entry),
        .head      (head_entry),
        .count     (queue_count)
    );

    // --------------------
    // pc source and flushes, lowest priority first
    always_comb begin
        pc_mux_sel                 = lc3b_pc_mux_sel_pc_plus2;
        control_request            = '0;
        debug_prediction_correct   = 1'b0;
        debug_prediction_incorrect = 1'b0;

        if (if_br && branch_prediction) begin
            pc_mux_sel = lc3b_pc_mux_sel_branch_address;
        end

        if (ex_br) begin
            if (mispredict) begin
                debug_prediction_incorrect           = 1'b1;
                pc_mux_sel                           = lc3b_pc_mux_sel_mispredict_address;
                control_request.barrier_if_id_reset  = 1'b1;
                control_request.barrier_id_ex_reset  = 1'b1;
                control_request.barrier_ex_mem_reset = 1'b1;
            end else begin
                debug_prediction_correct = 1'b1;
                pc_mux_sel               = lc3b_pc_mux_sel_pc_plus2;
            end
        end

        if (ex_trap || ex_jump) begin
            control_request.barrier_if_id_reset  = 1'b1;
            control_request.barrier_id_ex_reset  = 1'b1;
            control_request.barrier_ex_mem_reset = 1'b1;
        end

        if (ex_jump) begin
            pc_mux_sel = ex_mem.pc_mux_sel; // alu or pcn
        end

        if (wb_trap) begin
            pc_mux_sel                           = lc3b_pc_mux_sel_mdr;
            control_request.barrier_if_id_reset  = 1'b1;
            control_request.barrier_id_ex_reset  = 1'b1;
            control_request.barrier_ex_mem_reset = 1'b1;
            control_request.barrier_mem_wb_reset = 1'b1;
        end

        control_request.active = control_request.barrier_if_id_reset
                              || control_request.barrier_mem_wb_reset;
    end

    always_comb begin
        case (pc_mux_sel)
            lc3b_pc_mux_sel_alu:                pc_out = ex_mem.alu;
            lc3b_pc_mux_sel_pcn:                pc_out = ex_mem.pcn;
            lc3b_pc_mux_sel_mdr:                pc_out = mem_wb_mdr;
            lc3b_pc_mux_sel_branch_address:     pc_out = branch_address;
            lc3b_pc_mux_sel_mispredict_address: pc_out = head_entry.alternate_address;
            default:                            pc_out = pc_plus2_out;
        endcase
    end

    // --------------------
    // predictor training, one cycle after resolve
    always_ff @(posedge clk) begin
        if (reset) begin
            train <= 1'b0;
        end else begin
            train <= ex_br && (queue_count != '0);
        end
    end

    always_ff @(posedge clk) begin
        train_taken <= ex_mem.br_en;
        train_index <= head_entry.pht_index;
    end

endmodule : branch_controller

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter lc3b_types::lc3b_word reset_vector = 16'h0000,
    parameter int                   index_bits   = 6
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  lc3b_types::lc3b_word  next_pc,
    output lc3b_types::lc3b_word  pc,
    output logic                  prediction,
    input  logic                  train,
    input  logic                  train_taken,
    input  logic [index_bits-1:0] train_index
);

    // --------------------
    // program counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    // word address selects the counter
    branch_predictor #(
        .index_bits(index_bits)
    ) i_predictor (
        .clk          (clk),
        .reset        (reset),
        .read_index   (pc[index_bits:1]),
        .prediction   (prediction),
        .update       (train),
        .taken        (train_taken),
        .update_index (train_index)
    );

endmodule : fetch_stage

`default_nettype wire

// File: rtl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
    parameter int index_bits = 6
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [index_bits-1:0] read_index,
    output logic                  prediction,
    input  logic                  update,
    input  logic                  taken,
    input  logic [index_bits-1:0] update_index
);

    localparam int entries = 2 ** index_bits;

    // --------------------
    // pattern history table
    logic [1:0] pht [entries];
    logic [1:0] current;

    assign prediction = pht[read_index][1]; // upper bit is the guess
    assign current    = pht[update_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                pht[i] <= 2'b01; // weakly not taken
            end
        end else if (update) begin
            if (taken) begin
                if (current != 2'b11) begin
                    pht[update_index] <= current + 2'b01;
                end
            end else begin
                if (current != 2'b00) begin
                    pht[update_index] <= current - 2'b01;
                end
            end
        end
    end

endmodule : branch_predictor

`default_nettype wire

// File: rtl/branch_waterfall_queue.sv
`timescale 1ns/1ps
`default_nettype none

module branch_waterfall_queue #(
    parameter type payload_t = logic [15:0],
    parameter int  depth     = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  logic                       flush,
    input  payload_t                   push_data,
    output payload_t                   head,
    output logic [$clog2(depth+1)-1:0] count
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

    payload_t            entries [depth];
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] wr_ptr;
    logic                do_push;
    logic                do_pop;

    assign do_pop  = pop && (count != '0) && !flush;
    assign do_push = push && (count != ($clog2(depth+1))'(depth)) && !flush; // full drops

    // oldest entry, zero when empty
    assign head = (count != '0) ? entries[rd_ptr] : '0;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule : branch_waterfall_queue

`default_nettype wire

// File: rtl/ex_mem_resolve_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_resolve_if;
    import lc3b_types::*;

    logic           valid;
    lc3b_opcode     opcode;
    lc3b_word       alu;
    lc3b_word       pcn;
    lc3b_pc_mux_sel pc_mux_sel; // from the ex/mem control word
    logic           br_en;      // from mem stage

    modport barrier (
        output valid, opcode, alu, pcn, pc_mux_sel, br_en
    );

    modport controller (
        input valid, opcode, alu, pcn, pc_mux_sel, br_en
    );

endinterface : ex_mem_resolve_if

`default_nettype wire

// File: rtl/lc3b_types.sv
`default_nettype none

package lc3b_types;

    // width of the pattern history table index
    parameter int PHT_INDEX_BITS = 6;

    typedef logic [15:0] lc3b_word;

    // --------------------
    // opcodes
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // --------------------
    // next-pc sources
    typedef enum logic [2:0] {
        lc3b_pc_mux_sel_pc_plus2           = 3'd0,
        lc3b_pc_mux_sel_alu                = 3'd1, // jmp, jsrr
        lc3b_pc_mux_sel_pcn                = 3'd2, // jsr offset
        lc3b_pc_mux_sel_mdr                = 3'd3, // trap vector
        lc3b_pc_mux_sel_branch_address     = 3'd4,
        lc3b_pc_mux_sel_mispredict_address = 3'd5
    } lc3b_pc_mux_sel;

    // --------------------
    // barrier flush request
    typedef struct packed {
        logic active;
        logic barrier_if_id_reset;
        logic barrier_id_ex_reset;
        logic barrier_ex_mem_reset;
        logic barrier_mem_wb_reset;
    } lc3b_pipeline_control_word;

    // one in-flight branch
    typedef struct packed {
        lc3b_word                  alternate_address; // pc if the guess was wrong
        logic                      prediction;
        logic [PHT_INDEX_BITS-1:0] pht_index;
    } lc3b_branch_entry;

endpackage : lc3b_types

`default_nettype wire
